// File: build.f
+incdir+src
src/ps2_pkg.sv
src/ps2_frame_tx.sv
src/ps2_frame_rx.sv
src/ps2_frame_timer.sv
src/ps2_rx_merge.sv
src/ps2_link_top.sv
testbench/ps2_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the PS/2 loopback testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module ps2_link_tb \
	-f build.f \
	-o ps2_link_sim

# Exit status of the simulation is the result
./obj_dir/ps2_link_sim

// File: testbench/ps2_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_settings.svh"

module ps2_link_tb
	import ps2_pkg::*;
();

	localparam int FRAME_CYCLES    = 11 * 2 * `PS2_HALF_BIT + 8;
	localparam int HOLD_CYCLES     = `PS2_TIMEOUT_CYCLES + 16;
	localparam int WATCHDOG_CYCLES = 40 * FRAME_CYCLES + 4 * HOLD_CYCLES + 100;

	logic          clk;
	logic          reset;
	logic          send;
	ps2_tx_req_t   req;
	logic          tx_busy;
	logic          ps2_clock;
	logic          ps2_data;
	ps2_rx_event_t rx_event;
	logic [7:0]    err_count;

	ps2_rx_event_t exp_q[$];
	ps2_rx_event_t exp_head;
	logic          exp_ready;
	logic [7:0]    err_model;
	logic [7:0]    err_on_event;
	logic [7:0]    err_next;
	integer        seed;

	ps2_link_top u_ps2_link_top (
		.clk       (clk),
		.reset     (reset),
		.send      (send),
		.req       (req),
		.tx_busy   (tx_busy),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data),
		.rx_event  (rx_event),
		.err_count (err_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic end_with_failure;
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("ERR %s exp %0h got %0h", name, exp, got);
		end_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		end_with_failure();
	endtask

	// Event the host side should report for a request
	function automatic ps2_rx_event_t expected_event(input ps2_tx_req_t r);
		ps2_rx_event_t ev;
		ev       = '0;
		ev.valid = 1'b1;
		if (r.abort)
			ev.timeout = 1'b1;
		else
		begin
			ev.data       = r.data;
			ev.parity_err = r.bad_parity;
		end
		return ev;
	endfunction

	// Saturating count after one more event
	function automatic logic [7:0] errors_after(input logic [7:0] count,
		input ps2_rx_event_t ev);
		if ((ev.parity_err || ev.stop_err || ev.timeout) && count != 8'hff)
			return count + 8'd1;
		return count;
	endfunction

	//////////////////////////////
	// Expected event tracking
	//////////////////////////////

	always @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			exp_q.delete();
			exp_head     <= '0;
			exp_ready    <= 1'b0;
			err_model    <= '0;
			err_on_event <= '0;
		end
		else
		begin
			err_next = err_model;
			if (rx_event.valid && exp_q.size() != 0)
			begin
				err_next = errors_after(err_model, exp_q[0]);
				void'(exp_q.pop_front());
			end
			// Only a send seen while idle starts a frame
			if (send && !tx_busy)
				exp_q.push_back(expected_event(req));
			err_model <= err_next;
			exp_ready <= (exp_q.size() != 0);
			if (exp_q.size() != 0)
			begin
				exp_head     <= exp_q[0];
				err_on_event <= errors_after(err_next, exp_q[0]);
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	event_expected: assert property (@(posedge clk) disable iff (!reset)
		rx_event.valid |-> exp_ready)
		else report_problem("rx_event.valid with no frame pending");

	event_data: assert property (@(posedge clk) disable iff (!reset)
		rx_event.valid && exp_ready |-> rx_event.data == exp_head.data)
		else report_value("rx_event.data", 32'($sampled(exp_head.data)),
			32'($sampled(rx_event.data)));

	event_flags: assert property (@(posedge clk) disable iff (!reset)
		rx_event.valid && exp_ready |->
		{rx_event.parity_err, rx_event.stop_err, rx_event.timeout} ==
		{exp_head.parity_err, exp_head.stop_err, exp_head.timeout})
		else report_value("rx_event.{parity_err,stop_err,timeout}",
			32'($sampled({exp_head.parity_err, exp_head.stop_err, exp_head.timeout})),
			32'($sampled({rx_event.parity_err, rx_event.stop_err, rx_event.timeout})));

	// Count steps on the same edge that registers the event
	err_tracks: assert property (@(posedge clk) disable iff (!reset)
		err_count == (rx_event.valid ? err_on_event : err_model))
		else report_value("err_count",
			32'($sampled(rx_event.valid ? err_on_event : err_model)),
			32'($sampled(err_count)));

	data_quiet_low: assert property (@(posedge clk) disable iff (!reset)
		!ps2_clock |-> $stable(ps2_data))
		else report_problem("ps2_data changed while ps2_clock was low");

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic check_idle;
		assert (tx_busy == 1'b0) else report_value("tx_busy", 32'h0, 32'(tx_busy));
		assert (rx_event.valid == 1'b0)
			else report_value("rx_event.valid", 32'h0, 32'(rx_event.valid));
		assert (err_count == 8'h00) else report_value("err_count", 32'h0, 32'(err_count));
		assert (ps2_clock == 1'b1) else report_value("ps2_clock", 32'h1, 32'(ps2_clock));
		assert (ps2_data == 1'b1) else report_value("ps2_data", 32'h1, 32'(ps2_data));
	endtask

	// One frame with an optional second send while the first is busy
	task automatic send_frame(input logic [7:0] data, input logic bad_parity,
		input logic abort, input logic poke);
		req.data       = data;
		req.bad_parity = bad_parity;
		req.abort      = abort;
		send           = 1'b1;
		@(posedge clk);
		#1;
		send = 1'b0;
		assert (tx_busy) else report_problem("send from idle was not accepted");
		if (poke)
		begin
			repeat (3 * `PS2_HALF_BIT) @(posedge clk);
			#1;
			req.data = ~data;
			send     = 1'b1;
			@(posedge clk);
			#1;
			send = 1'b0;
		end
		while (tx_busy)
		begin
			@(posedge clk);
			#1;
		end
		repeat (4) @(posedge clk);
		#1;
		assert (exp_q.size() == 0) else report_problem("frame ended without its event");
	endtask

	initial
	begin
		int i;
		seed  = 32'hcb39_e8d0;
		reset = 1'b0;
		send  = 1'b0;
		req   = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;
		check_idle();

		send_frame(8'h00, 1'b0, 1'b0, 1'b0);
		send_frame(8'hff, 1'b0, 1'b0, 1'b0);
		for (i = 0; i < 12; i++)
			send_frame(8'($random(seed)), 1'b0, 1'b0, i == 5);
		for (i = 0; i < 3; i++)
			send_frame(8'($random(seed)), 1'b1, 1'b0, 1'b0);
		// Stalled frames each followed by a clean one
		for (i = 0; i < 2; i++)
		begin
			send_frame(8'($random(seed)), 1'b0, 1'b1, 1'b0);
			send_frame(8'($random(seed)), 1'b0, 1'b0, 1'b0);
		end
		for (i = 0; i < 10; i++)
			send_frame(8'($random(seed)), 1'b0, 1'b0, 1'b0);

		$display("Everything OK");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_problem("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

// File: src/ps2_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_link_top
	import ps2_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          send,
	input  ps2_tx_req_t   req,
	output logic          tx_busy,
	output logic          ps2_clock,
	output logic          ps2_data,
	output ps2_rx_event_t rx_event,
	output logic [7:0]    err_count
);

	logic          in_frame;
	logic          timeout;
	ps2_rx_frame_t frame;

	//////////////////////////////
	// Device side
	//////////////////////////////

	// Lines are plain wires from the device that idle high
	ps2_frame_tx u_ps2_frame_tx (
		.clk       (clk),
		.reset     (reset),
		.send      (send),
		.req       (req),
		.busy      (tx_busy),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data)
	);

	//////////////////////////////
	// Host side
	//////////////////////////////

	ps2_frame_rx u_ps2_frame_rx (
		.clk       (clk),
		.reset     (reset),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data),
		.timeout   (timeout),
		.in_frame  (in_frame),
		.frame     (frame)
	);

	ps2_frame_timer u_ps2_frame_timer (
		.clk       (clk),
		.reset     (reset),
		.ps2_clock (ps2_clock),
		.in_frame  (in_frame),
		.timeout   (timeout)
	);

	ps2_rx_merge u_ps2_rx_merge (
		.clk       (clk),
		.reset     (reset),
		.frame     (frame),
		.timeout   (timeout),
		.rx_event  (rx_event),
		.err_count (err_count)
	);

endmodule

`default_nettype wire

// File: src/ps2_rx_merge.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx_merge
	import ps2_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  ps2_rx_frame_t frame,
	input  logic          timeout,
	output ps2_rx_event_t rx_event,
	output logic [7:0]    err_count
);

	logic is_err;

	assign is_err = timeout | (frame.done & (frame.parity_err | frame.stop_err));

	//////////////////////////////
	// Event register
	//////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			rx_event  <= '0;
			err_count <= '0;
		end
		else
		begin
			rx_event.valid <= frame.done | timeout;
			// Timeout wins over a frame in the same cycle
			if (timeout)
			begin
				rx_event.data       <= '0;
				rx_event.parity_err <= 1'b0;
				rx_event.stop_err   <= 1'b0;
				rx_event.timeout    <= 1'b1;
			end
			else if (frame.done)
			begin
				rx_event.data       <= frame.data;
				rx_event.parity_err <= frame.parity_err;
				rx_event.stop_err   <= frame.stop_err;
				rx_event.timeout    <= 1'b0;
			end
			// Saturating error count
			if (is_err && err_count != 8'hff)
				err_count <= err_count + 8'd1;
		end
	end

	err_count_mono: assert property (@(posedge clk) disable iff (!reset)
		err_count >= $past(err_count))
		else $error("err_count decreased");

endmodule

`default_nettype wire

// File: src/ps2_frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_settings.svh"

module ps2_frame_timer (
	input  logic clk,
	input  logic reset,
	input  logic ps2_clock,
	input  logic in_frame,
	output logic timeout
);

	localparam int TIMEOUT = `PS2_TIMEOUT_CYCLES;
	localparam int CNT_W   = $clog2(TIMEOUT + 1);

	logic             clk_d;
	logic             fall;
	logic [CNT_W-1:0] stall_cnt;

	// Own edge detector kept apart from the receiver
	assign fall = clk_d & ~ps2_clock;

	//////////////////////////////
	// Stall counter
	//////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			clk_d     <= 1'b1;
			stall_cnt <= '0;
			timeout   <= 1'b0;
		end
		else
		begin
			clk_d   <= ps2_clock;
			timeout <= 1'b0;
			if (!in_frame || fall)
				stall_cnt <= '0;
			else if (stall_cnt != CNT_W'(TIMEOUT))
			begin
				stall_cnt <= stall_cnt + 1'b1;
				// Pulse as the count reaches the limit, then park there
				timeout   <= (stall_cnt == CNT_W'(TIMEOUT - 1));
			end
		end
	end

	// in_frame comes from the receiver, which clears it only after this pulse
	timeout_in_frame: assert property (@(posedge clk) disable iff (!reset)
		timeout |-> in_frame)
		else $error("timeout outside a frame");

endmodule

`default_nettype wire

// File: src/ps2_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx
	import ps2_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          ps2_clock,
	input  logic          ps2_data,
	input  logic          timeout,
	output logic          in_frame,
	output ps2_rx_frame_t frame
);

	logic        clk_d;
	logic        fall;
	logic [10:0] shift_q;
	logic [3:0]  bit_cnt;
	logic        done_q;

	assign fall = clk_d & ~ps2_clock;

	//////////////////////////////
	// Frame control
	//////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			clk_d    <= 1'b1;
			in_frame <= 1'b0;
			bit_cnt  <= '0;
			done_q   <= 1'b0;
		end
		else
		begin
			clk_d  <= ps2_clock;
			done_q <= 1'b0;
			if (timeout)
			begin
				// Stalled frame is dropped
				in_frame <= 1'b0;
				bit_cnt  <= '0;
			end
			else if (fall)
			begin
				if (!in_frame)
				begin
					// Low start bit opens a frame
					if (!ps2_data)
					begin
						in_frame <= 1'b1;
						bit_cnt  <= 4'd1;
					end
				end
				else if (bit_cnt == 4'd10)
				begin
					in_frame <= 1'b0;
					bit_cnt  <= '0;
					done_q   <= 1'b1;
				end
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// Bits arrive LSB first and shift in from the top
	always_ff @(posedge clk)
	begin
		if (fall)
			shift_q <= {ps2_data, shift_q[10:1]};
	end

	//////////////////////////////
	// Checked results
	//////////////////////////////

	// After eleven shifts the start bit sits in bit 0 and the stop bit in bit 10
	assign frame.done       = done_q;
	assign frame.data       = shift_q[8:1];
	assign frame.parity_err = ~^shift_q[9:1];
	assign frame.stop_err   = ~shift_q[10] | shift_q[0];

	done_single: assert property (@(posedge clk) disable iff (!reset)
		frame.done |=> !frame.done)
		else $error("frame.done high two cycles in a row");

endmodule

`default_nettype wire

// File: src/ps2_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_settings.svh"

module ps2_frame_tx
	import ps2_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        send,
	input  ps2_tx_req_t req,
	output logic        busy,
	output logic        ps2_clock,
	output logic        ps2_data
);

	localparam int HALF_BIT    = `PS2_HALF_BIT;
	localparam int HOLD_CYCLES = `PS2_TIMEOUT_CYCLES + 16;
	localparam int DIV_W       = $clog2(HALF_BIT);
	localparam int HOLD_W      = $clog2(HOLD_CYCLES);

	typedef enum logic [3:0] {
		IDLE,
		START,
		DATA0,
		DATA1,
		DATA2,
		DATA3,
		DATA4,
		DATA5,
		DATA6,
		DATA7,
		PARITY,
		STOP,
		HOLD
	} tx_state_t;

	tx_state_t         state;
	ps2_tx_req_t       req_q;
	logic [DIV_W-1:0]  div_cnt;
	logic [HOLD_W-1:0] hold_cnt;
	logic              clk_q;
	logic              half_done;
	logic              rise;
	logic [2:0]        bit_idx;
	logic              parity_bit;

	assign half_done  = (div_cnt == DIV_W'(HALF_BIT - 1));
	// Low to high transition of the generated clock
	assign rise       = half_done & ~clk_q;
	assign bit_idx    = 3'(state - DATA0);
	assign parity_bit = (~^req_q.data) ^ req_q.bad_parity;

	assign busy      = (state != IDLE);
	assign ps2_clock = clk_q;

	//////////////////////////////
	// Clock divider and FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state    <= IDLE;
			clk_q    <= 1'b1;
			div_cnt  <= '0;
			hold_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					clk_q   <= 1'b1;
					div_cnt <= '0;
					if (send)
						state <= START;
				end
				HOLD:
				begin
					// Clock parked high while the host side times out
					if (hold_cnt == HOLD_W'(HOLD_CYCLES - 1))
					begin
						hold_cnt <= '0;
						state    <= IDLE;
					end
					else
						hold_cnt <= hold_cnt + 1'b1;
				end
				default:
				begin
					if (half_done)
					begin
						div_cnt <= '0;
						clk_q   <= ~clk_q;
						// Next bit goes out while the clock is high
						if (rise)
						begin
							case (state)
								STOP:    state <= IDLE;
								DATA3:   state <= req_q.abort ? HOLD : DATA4;
								default: state <= tx_state_t'(state + 4'd1);
							endcase
						end
					end
					else
						div_cnt <= div_cnt + 1'b1;
				end
			endcase
		end
	end

	// Request captured on acceptance
	always_ff @(posedge clk)
	begin
		if (state == IDLE && send)
			req_q <= req;
	end

	// Data line follows the bit of the current state
	always_comb
	begin
		case (state)
			START:  ps2_data = 1'b0;
			DATA0, DATA1, DATA2, DATA3,
			DATA4, DATA5, DATA6, DATA7:
				ps2_data = req_q.data[bit_idx];
			PARITY: ps2_data = parity_bit;
			HOLD:   ps2_data = req_q.data[3];
			default: ps2_data = 1'b1;
		endcase
	end

	// Host samples on the falling edge, so data must be quiet during the low phase
	data_stable_low: assert property (@(posedge clk) disable iff (!reset)
		!ps2_clock |-> $stable(ps2_data))
		else $error("ps2_data changed while ps2_clock low");

endmodule

`default_nettype wire

// File: src/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

	//////////////////////////////
	// Transmit request
	//////////////////////////////

	typedef struct packed {
		logic [7:0] data;
		// Send inverted parity
		logic       bad_parity;
		// Stop the clock after data bit 3
		logic       abort;
	} ps2_tx_req_t;

	//////////////////////////////
	// Receive results
	//////////////////////////////

	// Decoded frame from the receiver
	typedef struct packed {
		logic       done;
		logic [7:0] data;
		logic       parity_err;
		logic       stop_err;
	} ps2_rx_frame_t;

	// Merged event stream with one cycle per event
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       parity_err;
		logic       stop_err;
		logic       timeout;
	} ps2_rx_event_t;

endpackage

`default_nettype wire

// File: src/ps2_settings.svh
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

//////////////////////////////
// PS/2 link timing
//////////////////////////////

// System clocks per half PS/2 clock period
// One full bit lasts twice this
`define PS2_HALF_BIT 8

// System clocks without a falling PS/2 clock edge before a frame counts as stalled
`define PS2_TIMEOUT_CYCLES 64

`endif
